// ==== tests/regReadVectors.mem ====
// Digits: valid, op, addr, data(4) | expValid, expHit, expTag, expData(4).
// Ops: 0 nop, 1 write, 2 read, 3 clear. One command per line, one line per cycle.
12000001100000
12100001100000
12200001100000
12300001100000
12400001100000
12500001100000
112A5C30000000
02200000000000
1220000111A5C3
11312340000000
12300001111234
11500010000000
11500020000000
11500030000000
11500040000000
11500050000000
11500060000000
11500070000000
11500080000000
11500090000000
115000A0000000
115000B0000000
115000C0000000
115000D0000000
115000E0000000
115000F0000000
11500100000000
11500110000000
12500001110011
1220000111A5C3
12600001000000
12700001000000
116FFFF0000000
117BEEF0000000
10000000000000
12100001100000
12300001111234
12600001000000
13000000000000
12500001100000
12200001100000
12300001100000
12700001000000

// ==== compile.f ====
source/regReadPkg.sv
source/muxBinGates.sv
source/cmdDecode.sv
source/regBank.sv
source/readResult.sv
source/regReadTop.sv
tests/regReadTb.sv

// ==== Makefile ====
# Builds and runs the register read-out testbench with Verilator.
# Run from the project root; the testbench reads its vectors from tests/.

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module regReadTb -Mdir obj_dir -f compile.f
	./obj_dir/VregReadTb | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/regReadTb.sv ====
/*
  Testbench for the register read-out block. It reads commands and their
  expected responses from the vector file, drives one command per clock
  and checks each response for content and for its two-cycle latency.
  Run it from the project root so that the vector path resolves.
*/

`timescale 1ns/1ps

module regReadTb;

  import regReadPkg::*;

  // --------------------------------------------------
  // Constants and types
  // --------------------------------------------------

  localparam int MaxVectors = 128;
  localparam int ClockPeriod = 4;
  localparam int ResetCycles = 3;
  // A read driven on one edge is loaded into decode on the next edge
  // and comes back as a response one edge after that.
  localparam int Latency = 2;
  localparam int MarginCycles = 10;

  // One line of the vector file. Every field is a whole number of hex digits.
  typedef struct packed {
    logic [3:0]  valid;
    logic [3:0]  op;
    logic [3:0]  addr;
    logic [15:0] data;
    logic [3:0]  expValid;
    logic [3:0]  expHit;
    logic [3:0]  expTag;
    logic [15:0] expData;
  } vectorT;

  // A response that is still owed by the DUT, with the cycle it is due in.
  typedef struct packed {
    logic        hit;
    tagT         tag;
    dataT        data;
    logic [31:0] dueCycle;
  } expectT;

  // --------------------------------------------------
  // Signals
  // --------------------------------------------------

  logic clk;
  logic rstN;
  logic cmdValid;
  cmdT cmd;
  logic respValid;
  respT resp;

  logic [$bits(vectorT)-1:0] vectorMem [MaxVectors];
  int numVectors = 0;
  int timeoutLimit = 0;
  int cycle = 0;
  // The vector that is on the DUT inputs right now.
  vectorT curVec;
  expectT expQ[$];

  regReadTop u_dut (
    .clk(clk),
    .rstN(rstN),
    .cmdValid(cmdValid),
    .cmd(cmd),
    .respValid(respValid),
    .resp(resp)
  );

  // --------------------------------------------------
  // Reporting
  // --------------------------------------------------

  task automatic stopOnError();
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      stopOnError();
    end
  endtask

  // Unread entries keep their fill, whose top digit no real line can have.
  function automatic int countVectors();
    int n;
    n = 0;
    while (n < MaxVectors && vectorMem[n][$bits(vectorT)-1 -: 4] != 4'hF) begin
      n++;
    end
    return n;
  endfunction

  // --------------------------------------------------
  // Clock, cycle count and timeout
  // --------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #(ClockPeriod / 2) clk = ~clk;
  end

  // The limit covers reset, every vector, the last latency and a margin.
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (timeoutLimit > 0 && cycle >= timeoutLimit) begin
      $display("Timeout: the run did not finish within %0d cycles, %0d responses pending.",
               timeoutLimit, expQ.size());
      stopOnError();
    end
  end

  // --------------------------------------------------
  // Response monitor
  // --------------------------------------------------

  // Everything is sampled on the falling edge, away from the driving edge.
  always @(negedge clk) begin
    expectT head;
    if (rstN) begin
      if (respValid) begin
        if (expQ.size() == 0) begin
          $display("Error at %0t ns: respValid was high with no read outstanding.", $time);
          stopOnError();
        end
        head = expQ.pop_front();
        if (head.dueCycle != 32'(cycle)) begin
          $display("Error at %0t ns: a response came in cycle %0d but was due in cycle %0d.",
                   $time, cycle, head.dueCycle);
          stopOnError();
        end
        checkEqual(32'(resp.hit), 32'(head.hit), "resp.hit");
        checkEqual(32'(resp.tag), 32'(head.tag), "resp.tag");
        checkEqual(32'(resp.data), 32'(head.data), "resp.data");
      end else if (expQ.size() != 0 && expQ[0].dueCycle <= 32'(cycle)) begin
        $display("Error at %0t ns: respValid stayed low for a read due in cycle %0d.",
                 $time, expQ[0].dueCycle);
        stopOnError();
      end
      // A read that is on the inputs now is owed two cycles from here.
      if (curVec.expValid[0]) begin
        expQ.push_back('{hit: curVec.expHit[0], tag: curVec.expTag, data: curVec.expData,
                         dueCycle: 32'(cycle + Latency)});
      end
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  initial begin
    vectorT v;
    rstN = 1'b0;
    cmdValid = 1'b0;
    cmd = '0;
    curVec = '0;
    // Fill with a marker plus the address so the end of the file is visible.
    for (int i = 0; i < MaxVectors; i++) begin
      vectorMem[i] = {4'hF, 52'(i)};
    end
    $readmemh("tests/regReadVectors.mem", vectorMem);
    numVectors = countVectors();
    if (numVectors == 0) begin
      $display("Error: no command lines were read from the vector file.");
      stopOnError();
    end
    timeoutLimit = numVectors + ResetCycles + Latency + MarginCycles;

    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;

    // One command per cycle, back to back, with no gaps of its own.
    for (int i = 0; i < numVectors; i++) begin
      v = vectorMem[i];
      cmdValid <= v.valid[0];
      cmd <= '{op: opT'(v.op[1:0]), addr: v.addr[AddrWidth-1:0], data: v.data};
      curVec <= v;
      @(posedge clk);
    end
    cmdValid <= 1'b0;
    cmd <= '0;
    curVec <= '0;

    // Let the last responses drain, then watch a few idle cycles for strays.
    while (expQ.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule : regReadTb

// ==== source/regReadTop.sv ====
/*
  Top level of the register read-out block. Chains decode, execute and
  result. A read command sampled on one edge returns its response two
  cycles later; other commands give no response.
*/

`timescale 1ns/1ps

module regReadTop (
  input  logic             clk,
  input  logic             rstN,
  input  logic             cmdValid,
  input  regReadPkg::cmdT  cmd,
  output logic             respValid,
  output regReadPkg::respT resp
);

  import regReadPkg::*;

  // Decoded command, valid one cycle after the strobe.
  decodedT dec;

  // Combinational read of the register bank.
  dataT rdData;
  tagT rdTag;
  logic rdHit;

  cmdDecode decode (
    .clk(clk),
    .rstN(rstN),
    .cmdValid(cmdValid),
    .cmd(cmd),
    .dec(dec)
  );

  // The write lands on the edge where the next command's decode loads,
  // so a read right after a write sees the new value.
  regBank execute (
    .clk(clk),
    .rstN(rstN),
    .dec(dec),
    .rdData(rdData),
    .rdTag(rdTag),
    .rdHit(rdHit)
  );

  readResult result (
    .clk(clk),
    .rstN(rstN),
    .doRead(dec.doRead),
    .rdData(rdData),
    .rdTag(rdTag),
    .rdHit(rdHit),
    .respValid(respValid),
    .resp(resp)
  );

endmodule : regReadTop

// ==== source/readResult.sv ====
/*
  Result stage. Captures the read data, tag and hit flag into the
  response on the edge after a decoded read, and pulses respValid for
  that one cycle. The response holds between reads.
*/

`timescale 1ns/1ps

module readResult (
  input  logic             clk,
  input  logic             rstN,
  input  logic             doRead,
  input  regReadPkg::dataT rdData,
  input  regReadPkg::tagT  rdTag,
  input  logic             rdHit,
  output logic             respValid,
  output regReadPkg::respT resp
);

  import regReadPkg::*;

  // One strobe per read, no back-pressure.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      respValid <= 1'b0;
    end else begin
      respValid <= doRead;
    end
  end

  // Only a read reloads the response.
  always_ff @(posedge clk) begin
    if (doRead) begin
      resp <= '{hit: rdHit, tag: rdTag, data: rdData};
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  // A miss must come back empty, which depends on the mux padding.
  assert property (@(posedge clk) disable iff (!rstN)
    respValid && !resp.hit |-> (resp.data == '0) && (resp.tag == '0))
    else $error("Missed read returned nonzero data or tag.");

endmodule : readResult

// ==== source/regBank.sv ====
/*
  Execute stage. Holds the data registers and their write counters,
  applies clears and in-range writes on the clock edge after decode,
  and reads both arrays through two gate-tree muxes addressed by the
  decoded address. The read outputs follow the decoded command directly.
*/

`timescale 1ns/1ps

module regBank (
  input  logic                clk,
  input  logic                rstN,
  input  regReadPkg::decodedT dec,
  output regReadPkg::dataT    rdData,
  output regReadPkg::tagT     rdTag,
  output logic                rdHit
);

  import regReadPkg::*;

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------

  dataT [NumRegs-1:0] regs;
  tagT [NumRegs-1:0] tags;

  // Writes above the last register are dropped.
  logic wrInRange;
  // Valid flag of the tag mux, checked against rdHit.
  logic tagHit;

  assign wrInRange = dec.addr < AddrWidth'(NumRegs);

  // A clear wins over everything and zeroes both arrays.
  // Each write bumps the tag of its register, wrapping at 16.
  always_ff @(posedge clk) begin
    if (!rstN || dec.doClear) begin
      regs <= '0;
      tags <= '0;
    end else if (dec.doWrite && wrInRange) begin
      regs[dec.addr] <= dec.data;
      tags[dec.addr] <= tags[dec.addr] + TagWidth'(1);
    end
  end

  // ------------------------------------------------
  // Read path
  // ------------------------------------------------

  // Both muxes see the same select, so their valid flags match.
  muxBinGates #(
    .NumSymbols(NumRegs),
    .SymbolT(dataT)
  ) dataMux (
    .select(dec.addr),
    .in(regs),
    .out(rdData),
    .outValid(rdHit)
  );

  muxBinGates #(
    .NumSymbols(NumRegs),
    .SymbolT(tagT)
  ) tagMux (
    .select(dec.addr),
    .in(tags),
    .out(rdTag),
    .outValid(tagHit)
  );

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  assert property (@(posedge clk) disable iff (!rstN) rdHit == tagHit)
    else $error("Data and tag muxes disagree on the hit flag.");

  // State moves only on a clear or an in-range write.
  assert property (@(posedge clk) disable iff (!rstN)
    !(dec.doClear || (dec.doWrite && wrInRange)) |=> $stable(regs) && $stable(tags))
    else $error("Register bank changed without a write or clear.");

endmodule : regBank

// ==== source/cmdDecode.sv ====
/*
  Command decode stage. Samples the command strobe and payload on each
  clock and turns the opcode into separate write, read and clear flags.
  The decoded command is valid one cycle after cmdValid.
*/

`timescale 1ns/1ps

module cmdDecode (
  input  logic                clk,
  input  logic                rstN,
  input  logic                cmdValid,
  input  regReadPkg::cmdT     cmd,
  output regReadPkg::decodedT dec
);

  import regReadPkg::*;

  // ------------------------------------------------
  // Registers
  // ------------------------------------------------

  // Control flags, cleared by reset.
  logic doWriteQ;
  logic doReadQ;
  logic doClearQ;

  // Payload, loaded every cycle.
  logic [AddrWidth-1:0] addrQ;
  dataT dataQ;

  // Each flag needs the strobe, so an idle cycle drops all three.
  // A NOP with a strobe also leaves them low.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      doWriteQ <= 1'b0;
      doReadQ <= 1'b0;
      doClearQ <= 1'b0;
    end else begin
      doWriteQ <= cmdValid && (cmd.op == OpWrite);
      doReadQ <= cmdValid && (cmd.op == OpRead);
      doClearQ <= cmdValid && (cmd.op == OpClear);
    end
  end

  always_ff @(posedge clk) begin
    addrQ <= cmd.addr;
    dataQ <= cmd.data;
  end

  assign dec = '{
    doWrite: doWriteQ,
    doRead:  doReadQ,
    doClear: doClearQ,
    addr:    addrQ,
    data:    dataQ
  };

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  // The execute stage relies on a single action per cycle.
  assert property (@(posedge clk) disable iff (!rstN)
    $onehot0({dec.doWrite, dec.doRead, dec.doClear}))
    else $error("More than one decoded action flag is set.");

endmodule : cmdDecode

// ==== source/muxBinGates.sv ====
/*
  N-to-1 multiplexer with a binary select, built as an explicit tree of
  two-input AND-OR selects, one tree level per select bit. The payload
  type is a parameter. Inputs are zero-padded to a power of two, so an
  out-of-range select gives zero; outValid flags an in-range select.
*/

`timescale 1ns/1ps

module muxBinGates #(
  // Number of inputs to select among. Must be at least 2.
  parameter int NumSymbols = 2,
  // Payload type of each input; any packed type works.
  parameter type SymbolT = logic [7:0],
  localparam int SelectWidth = $clog2(NumSymbols)
) (
  input  logic [SelectWidth-1:0]  select,
  input  SymbolT [NumSymbols-1:0] in,
  output SymbolT                  out,
  output logic                    outValid
);

  // ------------------------------------------------
  // Elaboration checks
  // ------------------------------------------------

  if (NumSymbols < 2) begin : genBadNumSymbols
    $error("muxBinGates needs NumSymbols of at least 2.");
  end

  // ------------------------------------------------
  // Gate tree
  // ------------------------------------------------

  localparam int SymbolWidth = $bits(SymbolT);
  localparam int PaddedNumSymbols = 2 ** SelectWidth;
  localparam int NumLevels = SelectWidth;

  // Level 0 holds the padded inputs and level NumLevels holds the result.
  // Each level halves the number of live entries; the rest are tied low.
  logic [NumLevels:0][PaddedNumSymbols-1:0][SymbolWidth-1:0] stages;

  // Real inputs fill the low entries of level 0, zeros fill the top.
  for (genvar j = 0; j < PaddedNumSymbols; j++) begin : genPad
    if (j < NumSymbols) begin : genIn
      assign stages[0][j] = in[j];
    end else begin : genZero
      assign stages[0][j] = '0;
    end
  end

  for (genvar i = 0; i < NumLevels; i++) begin : genLevel
    // Select bit i picks between neighbouring pairs of the level below.
    localparam int NumMuxes = PaddedNumSymbols >> (i + 1);

    for (genvar j = 0; j < NumMuxes; j++) begin : genMux
      assign stages[i+1][j] = ({SymbolWidth{~select[i]}} & stages[i][2*j]) |
                              ({SymbolWidth{select[i]}} & stages[i][2*j+1]);
    end

    // Upper entries of this level carry nothing.
    assign stages[i+1][PaddedNumSymbols-1:NumMuxes] = '0;
  end

  assign out = SymbolT'(stages[NumLevels][0]);

  // Selects at or above NumSymbols land on padding.
  assign outValid = select < NumSymbols;

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  // The padding must reach the output for every out-of-range select.
  always_comb begin
    assert final (outValid || stages[NumLevels][0] == '0)
      else $error("Out-of-range select produced a nonzero output.");
  end

endmodule : muxBinGates

// ==== source/regReadPkg.sv ====
/*
  Shared sizes, types and opcodes for the register read-out block.
  Every design file that needs a command, decoded control or response
  layout imports this package inside its module body.
*/

package regReadPkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------

  // Six registers, so addresses 6 and 7 fall outside the bank.
  localparam int NumRegs = 6;
  localparam int AddrWidth = 3;
  localparam int DataWidth = 16;
  // Write counters wrap after 16 writes.
  localparam int TagWidth = 4;

  // ------------------------------------------------
  // Types
  // ------------------------------------------------

  typedef logic [DataWidth-1:0] dataT;
  typedef logic [TagWidth-1:0] tagT;

  // Opcode carried in the external command.
  typedef enum logic [1:0] {
    OpNop   = 2'd0,
    OpWrite = 2'd1,
    OpRead  = 2'd2,
    OpClear = 2'd3
  } opT;

  // External command, 21 bits.
  typedef struct packed {
    opT                   op;
    logic [AddrWidth-1:0] addr;
    dataT                 data;
  } cmdT;

  // Registered command after decode. At most one flag is set.
  typedef struct packed {
    logic                 doWrite;
    logic                 doRead;
    logic                 doClear;
    logic [AddrWidth-1:0] addr;
    dataT                 data;
  } decodedT;

  // Read response, 21 bits.
  typedef struct packed {
    logic hit;
    tagT  tag;
    dataT data;
  } respT;

endpackage : regReadPkg
